// ==== hw/spi_link_pkg.sv ====
`default_nettype none

package spi_link_pkg;

  // One SPI transfer unit, shifted MSB first on the wire
  typedef logic [7:0] spi_byte_t;

  // Bit position inside a byte
  typedef logic [2:0] bit_idx_t;

  // Bytes per host word
  // The top level passes this down as WORD_BYTES
  localparam int unsigned WORD_BYTES_DEFAULT = 8;

  // Repeated across the word when the host has nothing queued
  localparam spi_byte_t TX_FILL_BYTE = 8'hff;

  // Framer states
  // IDLE while chip select is high, ACTIVE while a frame is open
  typedef enum logic [0:0] {
    IDLE   = 1'b0,
    ACTIVE = 1'b1
  } frame_state_t;

endpackage

`default_nettype wire

// ==== hw/spi_pin_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_pin_sync (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  sck,
  input  wire  cs_n,
  input  wire  copi,
  output logic sck_rise,
  output logic sck_fall,
  output logic cs_active,
  output logic copi_s,
  output logic frame_start,
  output logic frame_end
);

  // Stage 0 and 1 form the synchronizer, stage 2 is the history flop
  logic [2:0] sck_r;
  logic [2:0] cs_r;
  logic [2:0] copi_r;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sck_r  <= 3'b000;
      // Chip select idles inactive so no frame starts out of reset
      cs_r   <= 3'b111;
      copi_r <= 3'b000;
    end else begin
      sck_r  <= {sck_r[1:0], sck};
      cs_r   <= {cs_r[1:0], cs_n};
      copi_r <= {copi_r[1:0], copi};
    end
  end

  // Edges from the two oldest stages
  assign sck_rise    = (sck_r[2:1] == 2'b01);
  assign sck_fall    = (sck_r[2:1] == 2'b10);
  // Chip select is active low on the pin
  assign cs_active   = ~cs_r[1];
  assign frame_start = (cs_r[2:1] == 2'b10);
  assign frame_end   = (cs_r[2:1] == 2'b01);
  // COPI settled half an SCK period before the rise, so the oldest stage is safe
  assign copi_s      = copi_r[2];

endmodule

`default_nettype wire

// ==== hw/spi_byte_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_byte_engine import spi_link_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        sck_rise,
  input  wire        sck_fall,
  input  wire        cs_active,
  input  wire        copi_s,
  input  spi_byte_t  tx_byte,
  output spi_byte_t  rx_byte,
  output logic       rx_byte_valid,
  output logic       cipo_bit
);

  // Receive position counts up, first bit is the MSB
  bit_idx_t rx_cnt;
  // Transmit position counts down from bit 7
  bit_idx_t tx_cnt;

  localparam bit_idx_t RX_START = 3'd0;
  localparam bit_idx_t TX_START = 3'd7;
  localparam bit_idx_t RX_LAST  = 3'd7;

  // Receive bit counter and byte strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_cnt        <= RX_START;
      rx_byte_valid <= 1'b0;
    end else begin
      // Strobe lasts a single cycle
      rx_byte_valid <= 1'b0;
      if (!cs_active) begin
        // Drop any partial byte between frames
        rx_cnt <= RX_START;
      end else if (sck_rise) begin
        // Wraps back to 0 after the eighth bit
        rx_cnt        <= rx_cnt + 3'd1;
        rx_byte_valid <= (rx_cnt == RX_LAST);
      end
    end
  end

  // Receive shift register
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      // Mode 0 samples on the rising edge, MSB arrives first
      rx_byte <= {rx_byte[6:0], copi_s};
    end
  end

  // Transmit bit counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_cnt <= TX_START;
    end else if (!cs_active) begin
      // Bit 7 is on the line as soon as the frame opens
      tx_cnt <= TX_START;
    end else if (sck_fall) begin
      // Rolls over to 7 on the eighth fall, ready for the next byte
      tx_cnt <= tx_cnt - 3'd1;
    end
  end

  // Controller samples on the rise, so the bit changes after each fall
  assign cipo_bit = tx_byte[tx_cnt];

endmodule

`default_nettype wire

// ==== hw/spi_word_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_word_framer import spi_link_pkg::*; #(
  parameter int unsigned WORD_BYTES = WORD_BYTES_DEFAULT
) (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      frame_start,
  input  wire                      frame_end,
  input  spi_byte_t                rx_byte,
  input  wire                      rx_byte_valid,
  input  wire  [WORD_BYTES*8-1:0]  next_word,
  output spi_byte_t                tx_byte,
  output logic                     word_take,
  output logic [WORD_BYTES*8-1:0]  rx_word,
  output logic                     rx_valid
);

  // Byte index needs at least one bit even for tiny words
  localparam int unsigned IDX_W = (WORD_BYTES > 1) ? $clog2(WORD_BYTES) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(WORD_BYTES - 1);

  typedef logic [WORD_BYTES*8-1:0] word_t;

  frame_state_t     state;
  logic [IDX_W-1:0] byte_idx;
  // Delayed take after the last byte of a word
  logic             take_r;
  // Partial word being assembled
  word_t            rx_shadow;
  word_t            rx_next;
  // Word currently being shifted out
  word_t            tx_word_r;
  logic             last_byte;

  // Current byte merged into the shadow at its little-endian slot
  always_comb begin
    rx_next = rx_shadow;
    rx_next[byte_idx*8 +: 8] = rx_byte;
  end

  assign last_byte = (state == ACTIVE) && rx_byte_valid && (byte_idx == LAST_IDX);

  // Frame tracking and byte counting
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= IDLE;
      byte_idx <= '0;
      take_r   <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      take_r   <= 1'b0;
      rx_valid <= 1'b0;
      if (frame_end) begin
        // Abort discards the alignment silently
        state    <= IDLE;
        byte_idx <= '0;
      end else if (frame_start) begin
        state    <= ACTIVE;
        byte_idx <= '0;
      end else if ((state == ACTIVE) && rx_byte_valid) begin
        if (last_byte) begin
          byte_idx <= '0;
          take_r   <= 1'b1;
          rx_valid <= 1'b1;
        end else begin
          byte_idx <= byte_idx + 1'b1;
        end
      end
    end
  end

  // Receive assembly and word hand-off
  always_ff @(posedge clk) begin
    if ((state == ACTIVE) && rx_byte_valid) begin
      rx_shadow <= rx_next;
    end
    if (last_byte) begin
      rx_word <= rx_next;
    end
  end

  // One take per frame opening and one per completed word
  assign word_take = frame_start | take_r;

  // Mailbox answers in the same cycle
  always_ff @(posedge clk) begin
    if (word_take) begin
      tx_word_r <= next_word;
    end
  end

  // LSB first across the word
  assign tx_byte = tx_word_r[byte_idx*8 +: 8];

endmodule

`default_nettype wire

// ==== hw/spi_mailbox.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_mailbox import spi_link_pkg::*; #(
  parameter int unsigned WORD_BYTES = WORD_BYTES_DEFAULT
) (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      tx_load,
  input  wire  [WORD_BYTES*8-1:0]  tx_word,
  input  wire                      word_take,
  output logic [WORD_BYTES*8-1:0]  next_word,
  output logic                     tx_empty,
  output logic                     tx_underrun
);

  typedef logic [WORD_BYTES*8-1:0] word_t;

  // Fill pattern, one fill byte per word byte
  localparam word_t FILL_WORD = {WORD_BYTES{TX_FILL_BYTE}};

  // Pending host word and its valid flag
  word_t pending;
  logic  full;

  // Host writes always win
  always_ff @(posedge clk) begin
    if (tx_load) begin
      pending <= tx_word;
    end
  end

  // Occupancy
  // A load in the take cycle stays queued for the following take
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (tx_load) begin
      full <= 1'b1;
    end else if (word_take) begin
      full <= 1'b0;
    end
  end

  // Underrun strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_underrun <= 1'b0;
    end else begin
      // Pulses once per take that found no word
      tx_underrun <= word_take && !full;
    end
  end

  // Answer the framer combinationally in the take cycle
  assign next_word = full ? pending : FILL_WORD;

  // Host polls this before loading
  assign tx_empty  = ~full;

endmodule

`default_nettype wire

// ==== hw/spi_word_link.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_word_link import spi_link_pkg::*; #(
  parameter int unsigned WORD_BYTES = WORD_BYTES_DEFAULT
) (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      sck,
  input  wire                      cs_n,
  input  wire                      copi,
  input  wire                      tx_load,
  input  wire  [WORD_BYTES*8-1:0]  tx_word,
  output wire                      cipo,
  output logic                     tx_empty,
  output logic                     tx_underrun,
  output logic [WORD_BYTES*8-1:0]  rx_word,
  output logic                     rx_valid
);

  // Synchronized pin events
  logic sck_rise;
  logic sck_fall;
  logic cs_active;
  logic copi_s;
  logic frame_start;
  logic frame_end;

  // Byte level traffic
  spi_byte_t rx_byte;
  logic      rx_byte_valid;
  spi_byte_t tx_byte;
  logic      cipo_bit;

  // Word hand-off between framer and mailbox
  logic                    word_take;
  logic [WORD_BYTES*8-1:0] next_word;

  spi_pin_sync u_pin_sync (
    .clk         (clk),
    .rst_n       (rst_n),
    .sck         (sck),
    .cs_n        (cs_n),
    .copi        (copi),
    .sck_rise    (sck_rise),
    .sck_fall    (sck_fall),
    .cs_active   (cs_active),
    .copi_s      (copi_s),
    .frame_start (frame_start),
    .frame_end   (frame_end)
  );

  spi_byte_engine u_byte_engine (
    .clk           (clk),
    .rst_n         (rst_n),
    .sck_rise      (sck_rise),
    .sck_fall      (sck_fall),
    .cs_active     (cs_active),
    .copi_s        (copi_s),
    .tx_byte       (tx_byte),
    .rx_byte       (rx_byte),
    .rx_byte_valid (rx_byte_valid),
    .cipo_bit      (cipo_bit)
  );

  spi_word_framer #(
    .WORD_BYTES (WORD_BYTES)
  ) u_word_framer (
    .clk           (clk),
    .rst_n         (rst_n),
    .frame_start   (frame_start),
    .frame_end     (frame_end),
    .rx_byte       (rx_byte),
    .rx_byte_valid (rx_byte_valid),
    .next_word     (next_word),
    .tx_byte       (tx_byte),
    .word_take     (word_take),
    .rx_word       (rx_word),
    .rx_valid      (rx_valid)
  );

  spi_mailbox #(
    .WORD_BYTES (WORD_BYTES)
  ) u_mailbox (
    .clk         (clk),
    .rst_n       (rst_n),
    .tx_load     (tx_load),
    .tx_word     (tx_word),
    .word_take   (word_take),
    .next_word   (next_word),
    .tx_empty    (tx_empty),
    .tx_underrun (tx_underrun)
  );

  // Release the shared CIPO line outside our frame
  assign cipo = cs_active ? cipo_bit : 1'bz;

endmodule

`default_nettype wire

// ==== tests/spi_controller_model.svh ====
`ifndef SPI_CONTROLLER_MODEL_SVH
`define SPI_CONTROLLER_MODEL_SVH

// Bytes shifted out on COPI, byte 0 first, each one MSB first
spi_byte_t copi_bytes[$];
// Complete bytes captured from CIPO on the rising SCK edges
spi_byte_t cipo_bytes[$];

// Step to 1 ns past a later clock edge so no pin moves on an edge
task automatic wait_clocks(input int unsigned n);
  repeat (n) begin
    @(posedge clk);
    #1;
  end
endtask

// One mode 0 bit on a 160 ns SCK period
// COPI changes while SCK is low, CIPO is sampled on the rise
task automatic shift_bit(input logic out_bit, output logic in_bit);
  copi = out_bit;
  wait_clocks(4);
  sck    = 1'b1;
  in_bit = cipo;
  wait_clocks(4);
  sck = 1'b0;
endtask

// Frame of bit_count bits taken from copi_bytes
// Chip select may drop after any bit, a partial CIPO byte is dropped
task automatic run_frame(input int unsigned bit_count);
  spi_byte_t   out_byte;
  spi_byte_t   in_byte;
  logic        in_bit;
  int unsigned k;
  cipo_bytes.delete();
  in_byte = '0;
  cs_n    = 1'b0;
  // Setup time before the first rise is covered by the first low phase
  for (k = 0; k < bit_count; k++) begin
    out_byte = copi_bytes[k / 8];
    shift_bit(out_byte[7 - (k % 8)], in_bit);
    in_byte = {in_byte[6:0], in_bit};
    if ((k % 8) == 7) begin
      cipo_bytes.push_back(in_byte);
    end
  end
  // Hold after the last fall, then the gap between frames
  wait_clocks(4);
  cs_n = 1'b1;
  copi = 1'b0;
  wait_clocks(8);
endtask

`endif

// ==== tests/spi_word_link_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_word_link_tb import spi_link_pkg::*; ();

  localparam int unsigned WORD_BYTES = 8;
  localparam int unsigned WAIT_LIMIT = 4000;
  typedef logic [WORD_BYTES*8-1:0] word_t;
  // Word the mailbox sends when the host is late
  localparam word_t FILL_WORD = {WORD_BYTES{TX_FILL_BYTE}};

  logic  clk;
  logic  rst_n;
  logic  sck;
  logic  cs_n;
  logic  copi;
  logic  tx_load;
  word_t tx_word;
  wire   cipo;
  logic  tx_empty;
  logic  tx_underrun;
  logic  rx_valid;
  word_t rx_word;

  // Scoreboard state
  word_t       expected_q[$];
  int unsigned errors = 0;
  int unsigned rx_seen = 0;
  int unsigned underruns = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;

  // 20 ns clock
  always #10 clk = ~clk;

  spi_word_link #(
    .WORD_BYTES (WORD_BYTES)
  ) u_spi_word_link (
    .clk         (clk),
    .rst_n       (rst_n),
    .sck         (sck),
    .cs_n        (cs_n),
    .copi        (copi),
    .tx_load     (tx_load),
    .tx_word     (tx_word),
    .cipo        (cipo),
    .tx_empty    (tx_empty),
    .tx_underrun (tx_underrun),
    .rx_word     (rx_word),
    .rx_valid    (rx_valid)
  );

  `include "spi_controller_model.svh"

  // Reference receive word: byte b of word w is the b-th byte of that word on COPI
  function automatic word_t expected_rx_word(input int unsigned w);
    word_t       assembled;
    int unsigned b;
    for (b = 0; b < WORD_BYTES; b++) begin
      assembled[b*8 +: 8] = copi_bytes[w*WORD_BYTES + b];
    end
    return assembled;
  endfunction

  // Reference CIPO stream, low byte of the host word goes first
  function automatic spi_byte_t expected_cipo_byte(input word_t value, input int unsigned b);
    return value[b*8 +: 8];
  endfunction

  function automatic word_t random_word();
    word_t       value;
    int unsigned b;
    for (b = 0; b < WORD_BYTES; b++) begin
      value[b*8 +: 8] = 8'($urandom);
    end
    return value;
  endfunction

  // Random COPI payload, optionally queued as expected words
  task automatic make_payload(input int unsigned n_words, input logic expect_rx);
    int unsigned i;
    copi_bytes.delete();
    for (i = 0; i < n_words * WORD_BYTES; i++) begin
      copi_bytes.push_back(8'($urandom));
    end
    for (i = 0; i < n_words; i++) begin
      if (expect_rx) begin
        expected_q.push_back(expected_rx_word(i));
      end
    end
  endtask

  // Single-cycle host load
  task automatic load_host_word(input word_t value);
    tx_word = value;
    tx_load = 1'b1;
    wait_clocks(1);
    tx_load = 1'b0;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    $display("Verification failed");
    $finish;
  endtask

  task automatic wait_tx_empty();
    int unsigned n;
    n = 0;
    while (tx_empty !== 1'b1 && n < WAIT_LIMIT) begin
      wait_clocks(1);
      n++;
    end
    if (tx_empty !== 1'b1) stop_on_timeout("tx_empty to rise after a word take");
  endtask

  task automatic wait_underrun(input int unsigned target);
    int unsigned n;
    n = 0;
    while (underruns < target && n < WAIT_LIMIT) begin
      wait_clocks(1);
      n++;
    end
    if (underruns < target) stop_on_timeout("a tx_underrun pulse");
  endtask

  task automatic wait_rx_count(input int unsigned target);
    int unsigned n;
    n = 0;
    while (rx_seen < target && n < WAIT_LIMIT) begin
      wait_clocks(1);
      n++;
    end
    if (rx_seen < target) stop_on_timeout("rx_valid of the last word in the frame");
  endtask

  // Compare captured CIPO bytes of word w against a host word
  task automatic check_cipo_word(input word_t value, input int unsigned w,
                                 input int unsigned n_bytes);
    int unsigned b;
    for (b = 0; b < n_bytes; b++) begin
      if (w*WORD_BYTES + b >= cipo_bytes.size()) begin
        $display("CIPO stream ended early, byte %0d of word %0d was never captured", b, w);
        errors++;
      end else if (cipo_bytes[w*WORD_BYTES + b] !== expected_cipo_byte(value, b)) begin
        $display("FAILED at %0t ns: CIPO word %0d byte %0d is %h, expected %h", $time, w, b,
                 cipo_bytes[w*WORD_BYTES + b], expected_cipo_byte(value, b));
        errors++;
      end
    end
  endtask

  task automatic report_test(input string name, input int unsigned err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("PASS %s", name);
    end else begin
      tests_failed++;
      $display("FAIL %s (%0d errors)", name, errors - err_before);
    end
  endtask

  // Monitor samples at the falling edge, away from register updates
  always @(negedge clk) begin : rx_monitor
    word_t exp_word;
    if (rst_n === 1'b1 && tx_underrun === 1'b1) begin
      underruns++;
    end
    if (rst_n === 1'b1 && rx_valid === 1'b1) begin
      rx_seen++;
      if (expected_q.size() == 0) begin
        $display("FAILED at %0t ns: rx_valid with no word expected, rx_word %h", $time, rx_word);
        errors++;
      end else begin
        exp_word = expected_q.pop_front();
        if (rx_word !== exp_word) begin
          $display("FAILED at %0t ns: rx_word %h, expected %h", $time, rx_word, exp_word);
          errors++;
        end
      end
    end
  end

  initial begin : main_sequence
    word_t       w0;
    word_t       w1;
    word_t       w2;
    int unsigned err0;
    int unsigned rx0;
    int unsigned ur0;
    void'($urandom(32'h8497_862c));
    clk     = 1'b0;
    rst_n   = 1'b0;
    sck     = 1'b0;
    cs_n    = 1'b1;
    copi    = 1'b0;
    tx_load = 1'b0;
    tx_word = '0;
    wait_clocks(8);
    rst_n = 1'b1;

    // Reset state
    err0 = errors;
    @(negedge clk);
    if (rx_valid !== 1'b0 || tx_underrun !== 1'b0 || tx_empty !== 1'b1) begin
      $display("FAILED at %0t ns: reset state rx_valid %b tx_underrun %b tx_empty %b",
               $time, rx_valid, tx_underrun, tx_empty);
      errors++;
    end
    if (cipo !== 1'bz) begin
      $display("FAILED at %0t ns: cipo is %b after reset, expected z", $time, cipo);
      errors++;
    end
    wait_clocks(1);
    report_test("reset state", err0);

    // One word each way, host restocks a spare so the closing take finds a word
    err0 = errors;
    rx0  = rx_seen;
    ur0  = underruns;
    w0   = random_word();
    load_host_word(w0);
    make_payload(1, 1'b1);
    fork
      run_frame(8 * WORD_BYTES);
      begin
        wait_tx_empty();
        load_host_word(random_word());
      end
    join
    wait_rx_count(rx0 + 1);
    check_cipo_word(w0, 0, WORD_BYTES);
    if (underruns != ur0) begin
      $display("FAILED at %0t ns: %0d tx_underrun pulses, expected 0", $time, underruns - ur0);
      errors++;
    end
    if (cipo !== 1'bz) begin
      $display("FAILED at %0t ns: cipo is %b between frames, expected z", $time, cipo);
      errors++;
    end
    report_test("single word", err0);

    // Three words in one frame, host loads each after tx_empty rises
    err0 = errors;
    rx0  = rx_seen;
    ur0  = underruns;
    w0   = random_word();
    w1   = random_word();
    w2   = random_word();
    load_host_word(w0);
    make_payload(3, 1'b1);
    fork
      run_frame(3 * 8 * WORD_BYTES);
      begin
        wait_tx_empty();
        load_host_word(w1);
        wait_tx_empty();
        load_host_word(w2);
        wait_tx_empty();
        load_host_word(random_word());
      end
    join
    wait_rx_count(rx0 + 3);
    if (rx_seen != rx0 + 3 || underruns != ur0) begin
      $display("FAILED at %0t ns: %0d rx_valid and %0d tx_underrun pulses, expected 3 and 0",
               $time, rx_seen - rx0, underruns - ur0);
      errors++;
    end
    check_cipo_word(w0, 0, WORD_BYTES);
    check_cipo_word(w1, 1, WORD_BYTES);
    check_cipo_word(w2, 2, WORD_BYTES);
    report_test("multi-word frame", err0);

    // Empty mailbox at frame start, fill word goes out
    err0 = errors;
    rx0  = rx_seen;
    ur0  = underruns;
    make_payload(1, 1'b1);
    fork
      run_frame(8 * WORD_BYTES);
      begin
        wait_underrun(ur0 + 1);
        load_host_word(random_word());
      end
    join
    wait_rx_count(rx0 + 1);
    check_cipo_word(FILL_WORD, 0, WORD_BYTES);
    if (underruns != ur0 + 1) begin
      $display("FAILED at %0t ns: %0d tx_underrun pulses, expected 1", $time, underruns - ur0);
      errors++;
    end
    report_test("underrun", err0);

    // Chip select drops after 3.5 bytes, then a clean frame
    err0 = errors;
    rx0  = rx_seen;
    w0   = random_word();
    load_host_word(w0);
    make_payload(1, 1'b0);
    run_frame(8 * 3 + 4);
    if (rx_seen != rx0) begin
      $display("FAILED at %0t ns: rx_valid pulsed for an aborted frame", $time);
      errors++;
    end
    check_cipo_word(w0, 0, 3);
    w1 = random_word();
    load_host_word(w1);
    make_payload(1, 1'b1);
    fork
      run_frame(8 * WORD_BYTES);
      begin
        wait_tx_empty();
        load_host_word(random_word());
      end
    join
    wait_rx_count(rx0 + 1);
    check_cipo_word(w1, 0, WORD_BYTES);
    report_test("aborted frame", err0);

    if (expected_q.size() != 0) begin
      $display("%0d expected words were never received", expected_q.size());
      errors++;
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== spi_word_link.f ====
+incdir+tests
hw/spi_link_pkg.sv
hw/spi_pin_sync.sv
hw/spi_byte_engine.sv
hw/spi_word_framer.sv
hw/spi_mailbox.sv
hw/spi_word_link.sv
tests/spi_word_link_tb.sv

// ==== Bender.yml ====
package:
  name: spi_word_link

sources:
  - files:
      - hw/spi_link_pkg.sv
      - hw/spi_pin_sync.sv
      - hw/spi_byte_engine.sv
      - hw/spi_word_framer.sv
      - hw/spi_mailbox.sv
      - hw/spi_word_link.sv
  - target: simulation
    include_dirs:
      - tests
    files:
      - tests/spi_word_link_tb.sv
